//--- common/spi_pkg.sv
// Types shared by the SPI master controller blocks
// Widths follow the settings header, so it is pulled in here first

`include "spi_settings.svh"

package spi_pkg;

  typedef logic [7:0]  spi_byte_t;   // One serial byte
  typedef logic [3:0]  axi_addr_t;   // Register offset, bits 1:0 ignored
  typedef logic [31:0] reg_data_t;   // AXI data word

  // Queue index and occupancy, count is one bit wider to hold a full queue
  typedef logic [$clog2(`SPI_RX_DEPTH)-1:0] rx_ptr_t;
  typedef logic [$clog2(`SPI_RX_DEPTH):0]   rx_count_t;

  // Engine counters
  typedef logic [$clog2(`SPI_CLKS_PER_HALF_BIT)-1:0] half_cnt_t;  // Cycles in a half bit
  typedef logic [4:0]                                edge_cnt_t;  // SCLK edges left, 0..16

  // Serial engine sequencing
  typedef enum logic [1:0] {
    IDLE,    // Waiting for a byte
    LOAD,    // Byte taken, counters set up
    SHIFT,   // SCLK running
    DONE     // Last edge seen, hand back the byte
  } engine_state_t;

  // AXI write channel handling
  typedef enum logic [1:0] {
    WR_IDLE,         // Ready for address and data
    WR_WAIT_ENGINE,  // TXDATA offered, engine still busy
    WR_RESP          // BVALID up until BREADY
  } axi_wr_state_t;

endpackage

//--- common/spi_settings.svh
// Build-time settings for the SPI master controller
// Included by the package and by every block that needs the mode,
// clock rate, queue depth or register map
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// SPI mode 0 to 3, bit 1 is CPOL and bit 0 is CPHA
`define SPI_MODE              0

// i_Clk cycles in each SCLK half period, at least 2
`define SPI_CLKS_PER_HALF_BIT 2

`define SPI_RX_DEPTH          4     // Receive queue entries, power of two

// Register byte offsets
`define SPI_REG_CTRL          4'h0  // Bit 0 is chip-select enable
`define SPI_REG_TXDATA        4'h4  // Write only
`define SPI_REG_RXDATA        4'h8  // Read only, pops the queue
`define SPI_REG_STATUS        4'hC  // Busy, empty, overrun, count

// AXI response codes
`define SPI_RESP_OKAY         2'b00
`define SPI_RESP_SLVERR       2'b10

`endif

//--- common/spi_xfer_if.sv
// Internal links of the SPI master controller
// spi_xfer_if moves bytes from the register decoder into the serial engine
// and received bytes on to the collector, rx_queue_if lets the decoder
// read and control the receive queue

`timescale 1ns/100ps

interface spi_xfer_if
  import spi_pkg::*;
();

  spi_byte_t tx_byte;    // Held by the decoder until accepted
  logic      tx_valid;
  logic      tx_ready;   // Low from acceptance until the byte ends
  spi_byte_t rx_byte;
  logic      rx_valid;   // Single-cycle pulse with rx_byte

  modport decoder   (output tx_byte, output tx_valid, input tx_ready);
  modport engine    (input tx_byte, input tx_valid, output tx_ready,
                     output rx_byte, output rx_valid);
  modport collector (input rx_byte, input rx_valid);

endinterface

interface rx_queue_if
  import spi_pkg::*;
();

  logic      pop;          // One-cycle pulse, head is consumed
  spi_byte_t rd_data;      // Head entry, combinational
  logic      empty;
  rx_count_t count;
  logic      overrun;      // Sticky until cleared
  logic      clr_overrun;  // One-cycle pulse

  modport decoder   (output pop, output clr_overrun,
                     input rd_data, input empty, input count, input overrun);
  modport collector (input pop, input clr_overrun,
                     output rd_data, output empty, output count, output overrun);

endinterface

//--- spi/spi_engine.sv
// SPI master serial engine
// Takes one byte at a time over the transfer interface, runs SCLK for the
// build-time mode, shifts MOSI out MSB first and samples MISO into a byte
// Chip select is driven by the register decoder, not here

`timescale 1ns/100ps
`include "spi_settings.svh"

module spi_engine
  import spi_pkg::*;
(
  input  logic       i_Clk,
  input  logic       i_Rst_L,
  spi_xfer_if.engine xfer,        // Byte in, byte out
  output logic       o_spi_sclk,
  output logic       o_spi_mosi,
  input  logic       i_spi_miso
);

  logic          cpol;            // SCLK idle level
  logic          cpha;            // 1 = drive on leading edge, sample on trailing
  engine_state_t state;
  half_cnt_t     half_cnt;        // i_Clk cycles into the current half bit
  edge_cnt_t     edges_left;      // SCLK edges still to make
  logic          r_sclk;          // Internal SCLK, one cycle ahead of the pin
  logic          lead_stb;        // Registered edge strobes
  logic          trail_stb;
  logic          accept;          // Byte taken this cycle
  logic          preload;         // Phase 0 puts the MSB out before any edge
  logic          out_stb;         // Edge that moves MOSI
  logic          in_stb;          // Edge that samples MISO
  spi_byte_t     tx_shift;
  spi_byte_t     rx_shift;

  assign cpol = (`SPI_MODE == 2) || (`SPI_MODE == 3);
  assign cpha = (`SPI_MODE == 1) || (`SPI_MODE == 3);

  assign accept  = (state == IDLE) && xfer.tx_valid && xfer.tx_ready;
  assign preload = (state == LOAD) && !cpha;
  assign out_stb = cpha ? lead_stb : trail_stb;
  assign in_stb  = cpha ? trail_stb : lead_stb;

  //////////////////////////////////////////////////////////////////////
  // Half-bit counter and SCLK edge sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      state         <= IDLE;
      xfer.tx_ready <= 1'b1;
      half_cnt      <= '0;
      edges_left    <= '0;
      r_sclk        <= cpol;
      lead_stb      <= 1'b0;
      trail_stb     <= 1'b0;
    end
    else
    begin
      lead_stb  <= 1'b0;            // Strobes live for one cycle
      trail_stb <= 1'b0;
      case (state)
        IDLE:
        begin
          if (accept)
          begin
            xfer.tx_ready <= 1'b0;  // Stays low for the whole byte
            state         <= LOAD;
          end
        end
        LOAD:
        begin
          half_cnt   <= '0;
          edges_left <= edge_cnt_t'(16);  // Two edges per bit
          state      <= SHIFT;
        end
        SHIFT:
        begin
          if (half_cnt == half_cnt_t'(`SPI_CLKS_PER_HALF_BIT - 1))
          begin
            half_cnt   <= '0;
            r_sclk     <= ~r_sclk;
            edges_left <= edges_left - 1'b1;
            lead_stb   <= ~edges_left[0];   // Even count left is a leading edge
            trail_stb  <= edges_left[0];
            if (edges_left == edge_cnt_t'(1))
              state <= DONE;                // Sixteenth edge
          end
          else
            half_cnt <= half_cnt + 1'b1;
        end
        DONE:
        begin
          xfer.tx_ready <= 1'b1;    // Same cycle as rx_valid
          state         <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data shifting
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clk)
  begin
    if (accept)
      tx_shift <= xfer.tx_byte;
    else if (preload || out_stb)
      tx_shift <= {tx_shift[6:0], 1'b0};  // Zeros follow, MOSI ends low

    if (in_stb)
      rx_shift <= {rx_shift[6:0], i_spi_miso};
  end

  assign xfer.rx_byte = rx_shift;

  // Pin stage, SCLK delayed one cycle so it moves together with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_spi_sclk    <= cpol;
      o_spi_mosi    <= 1'b0;
      xfer.rx_valid <= 1'b0;
    end
    else
    begin
      o_spi_sclk    <= r_sclk;
      xfer.rx_valid <= (state == DONE);  // Last sample lands on this edge
      if (preload || out_stb)
        o_spi_mosi <= tx_shift[7];
    end
  end

endmodule

//--- src.f
+incdir+common
common/spi_pkg.sv
common/spi_xfer_if.sv
spi/spi_engine.sv
verilog/spi_reg_decode.sv
verilog/spi_rx_collect.sv
verilog/spi_ctrl_top.sv
verif/spi_ctrl_assertions.sv
verif/spi_ctrl_tb.sv

//--- verif/spi_ctrl_assertions.sv
// Protocol checks for the SPI master controller
// Bound onto the top level, watches the AXI response channels, SCLK and the
// engine's receive strobe

`timescale 1ns/100ps
`include "spi_settings.svh"

module spi_ctrl_assertions (
  input logic i_Clk,
  input logic i_Rst_L,
  input logic i_axi_bvalid,
  input logic i_axi_bready,
  input logic i_axi_rvalid,
  input logic i_axi_rready,
  input logic i_spi_sclk,
  input logic i_tx_ready,           // High while no byte is in flight
  input logic i_rx_valid            // Engine byte-done pulse
);

  localparam logic CPOL = (((`SPI_MODE) >> 1) & 1) != 0;  // SCLK idle level

  int err_cnt = 0;                  // Assertion failures so far

  // Response valid holds until the host takes it
  bvalid_hold: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_axi_bvalid && !i_axi_bready |=> i_axi_bvalid)
  else
  begin
    $error("BVALID dropped before BREADY");
    err_cnt++;
  end

  rvalid_hold: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_axi_rvalid && !i_axi_rready |=> i_axi_rvalid)
  else
  begin
    $error("RVALID dropped before RREADY");
    err_cnt++;
  end

  // No byte in flight, so SCLK rests at CPOL
  sclk_idle: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_tx_ready |-> (i_spi_sclk == CPOL))
  else
  begin
    $error("SCLK away from its idle level while the engine is idle");
    err_cnt++;
  end

  rx_valid_pulse: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_rx_valid |=> !i_rx_valid)
  else
  begin
    $error("Engine rx_valid high for more than one cycle");
    err_cnt++;
  end

endmodule

bind spi_ctrl_top spi_ctrl_assertions spi_ctrl_assertions_inst (
  .i_Clk        (i_Clk),
  .i_Rst_L      (i_Rst_L),
  .i_axi_bvalid (o_axi_bvalid),
  .i_axi_bready (i_axi_bready),
  .i_axi_rvalid (o_axi_rvalid),
  .i_axi_rready (i_axi_rready),
  .i_spi_sclk   (o_spi_sclk),
  .i_tx_ready   (xfer_if.tx_ready),
  .i_rx_valid   (xfer_if.rx_valid)
);

//--- verif/spi_ctrl_tb.sv
// Testbench for the SPI master controller
// Drives the AXI4-Lite port, loops MOSI back into MISO and checks register
// results for loopback, ordering, overrun, error responses and idle lines

`timescale 1ns/100ps
`include "spi_settings.svh"

module spi_ctrl_tb
  import spi_pkg::*;
();

  localparam int   WAIT_LIMIT = 200;                    // Cycles per handshake wait
  localparam int   MAX_POLLS  = 100;                    // STATUS reads per poll
  localparam int   MIN_BP_LAT = 16 * `SPI_CLKS_PER_HALF_BIT - 4;  // Engine still busy
  localparam logic CPOL       = (((`SPI_MODE) >> 1) & 1) != 0;

  logic       i_Clk;
  logic       i_Rst_L;
  logic       i_axi_awvalid;
  logic       o_axi_awready;
  axi_addr_t  i_axi_awaddr;
  logic       i_axi_wvalid;
  logic       o_axi_wready;
  reg_data_t  i_axi_wdata;
  logic       o_axi_bvalid;
  logic       i_axi_bready;
  logic [1:0] o_axi_bresp;
  logic       i_axi_arvalid;
  logic       o_axi_arready;
  axi_addr_t  i_axi_araddr;
  logic       o_axi_rvalid;
  logic       i_axi_rready;
  reg_data_t  o_axi_rdata;
  logic [1:0] o_axi_rresp;
  logic       o_spi_sclk;
  logic       o_spi_mosi;
  logic       i_spi_miso;
  logic       o_spi_cs_n;

  string      test_name;
  int         test_errs;
  int         tests_passed = 0;
  int         tests_failed = 0;
  int         asrt_errs;
  spi_byte_t  sent [$];               // Bytes in send order

  assign i_spi_miso = o_spi_mosi;     // Loopback, each byte comes back as sent

  spi_ctrl_top spi_ctrl_top_inst (.*);

  initial
  begin
    i_Clk = 1'b0;
    forever #10 i_Clk = ~i_Clk;       // 20 ns period
  end

  task automatic stop_on_timeout(input string what);
    $display("Timed out waiting for %s in %s", what, test_name);
    $display("Test failed");
    $finish;
  endtask

  task automatic check_eq(input string what, input reg_data_t exp, input reg_data_t act);
    assert (act === exp)
    else
    begin
      $display("FAIL %s %s: expected %0h actual %0h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_at_least(input string what, input int min_val, input int act);
    assert (act >= min_val)
    else
    begin
      $display("FAIL %s %s: expected at least %0d actual %0d", test_name, what, min_val, act);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0)
    begin
      $display("PASS %s", test_name);
      tests_passed++;
    end
    else
    begin
      $display("FAIL %s: expected 0 wrong checks actual %0d", test_name, test_errs);
      tests_failed++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite host tasks
  //////////////////////////////////////////////////////////////////////

  // lat counts cycles from the address/data handshake to BVALID
  task automatic axi_write(input axi_addr_t addr, input reg_data_t data,
                           output logic [1:0] resp, output int lat);
    int cnt;
    @(posedge i_Clk);
    #2;
    i_axi_awvalid = 1'b1;
    i_axi_awaddr  = addr;
    i_axi_wvalid  = 1'b1;
    i_axi_wdata   = data;
    cnt = 0;
    @(negedge i_Clk);
    while (!(o_axi_awready && o_axi_wready) && cnt < WAIT_LIMIT)
    begin
      @(negedge i_Clk);
      cnt++;
    end
    if (cnt >= WAIT_LIMIT)
      stop_on_timeout("AWREADY and WREADY");
    else
    begin
      @(posedge i_Clk);               // Handshake edge
      #2;
      i_axi_awvalid = 1'b0;
      i_axi_wvalid  = 1'b0;
      lat = 0;
      @(negedge i_Clk);
      while (!o_axi_bvalid && lat < WAIT_LIMIT)
      begin
        @(negedge i_Clk);
        lat++;
      end
      if (lat >= WAIT_LIMIT)
        stop_on_timeout("BVALID");
      else
      begin
        resp = o_axi_bresp;
        @(posedge i_Clk);
        #2;
        i_axi_bready = 1'b1;          // BVALID has waited with BREADY low
        @(posedge i_Clk);
        #2;
        i_axi_bready = 1'b0;
      end
    end
  endtask

  task automatic axi_read(input axi_addr_t addr, output reg_data_t data,
                          output logic [1:0] resp);
    int cnt;
    @(posedge i_Clk);
    #2;
    i_axi_arvalid = 1'b1;
    i_axi_araddr  = addr;
    cnt = 0;
    @(negedge i_Clk);
    while (!o_axi_arready && cnt < WAIT_LIMIT)
    begin
      @(negedge i_Clk);
      cnt++;
    end
    if (cnt >= WAIT_LIMIT)
      stop_on_timeout("ARREADY");
    else
    begin
      @(posedge i_Clk);
      #2;
      i_axi_arvalid = 1'b0;
      cnt = 0;
      @(negedge i_Clk);
      while (!o_axi_rvalid && cnt < WAIT_LIMIT)
      begin
        @(negedge i_Clk);
        cnt++;
      end
      if (cnt >= WAIT_LIMIT)
        stop_on_timeout("RVALID");
      else
      begin
        data = o_axi_rdata;
        resp = o_axi_rresp;
        @(posedge i_Clk);
        #2;
        i_axi_rready = 1'b1;
        @(posedge i_Clk);
        #2;
        i_axi_rready = 1'b0;
      end
    end
  endtask

  // Read STATUS until the masked bits match
  task automatic poll_status(input reg_data_t mask, input reg_data_t value,
                             input string what);
    reg_data_t  st;
    logic [1:0] resp;
    int         polls;
    polls = 0;
    do
    begin
      axi_read(`SPI_REG_STATUS, st, resp);
      polls++;
    end
    while (((st & mask) != value) && polls < MAX_POLLS);
    if ((st & mask) != value)
      stop_on_timeout(what);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    spi_byte_t  b;
    reg_data_t  rd;
    logic [1:0] resp;
    int         lat;

    void'($urandom(32'h3a2a_0bfa));
    i_Rst_L       = 1'b0;
    i_axi_awvalid = 1'b0;
    i_axi_awaddr  = '0;
    i_axi_wvalid  = 1'b0;
    i_axi_wdata   = '0;
    i_axi_bready  = 1'b0;
    i_axi_arvalid = 1'b0;
    i_axi_araddr  = '0;
    i_axi_rready  = 1'b0;
    repeat (3) @(posedge i_Clk);
    #2;
    i_Rst_L = 1'b1;

    // One byte out and back
    start_test("loopback");
    axi_write(`SPI_REG_CTRL, 32'h1, resp, lat);
    b = spi_byte_t'($urandom());
    axi_write(`SPI_REG_TXDATA, {24'h0, b}, resp, lat);
    check_eq("cs_n in transfer", 32'h0, o_spi_cs_n);
    axi_read(`SPI_REG_STATUS, rd, resp);
    check_eq("busy in transfer", 32'h1, rd[0]);
    poll_status(32'hF0, 32'h10, "a count of 1");
    axi_read(`SPI_REG_RXDATA, rd, resp);
    check_eq("rx byte", b, rd);
    check_eq("rx resp", `SPI_RESP_OKAY, resp);
    end_test();

    // Back-to-back writes, later ones wait on the engine
    start_test("ordering");
    sent.delete();
    for (int i = 0; i < 3; i++)
    begin
      b = spi_byte_t'($urandom());
      sent.push_back(b);
      axi_write(`SPI_REG_TXDATA, {24'h0, b}, resp, lat);
      if (i > 0)
        check_at_least("write response latency", MIN_BP_LAT, lat);
    end
    poll_status(32'hF0, 32'h30, "a count of 3");
    for (int i = 0; i < 3; i++)
    begin
      axi_read(`SPI_REG_RXDATA, rd, resp);
      check_eq($sformatf("rx byte %0d", i), sent[i], rd);
    end
    axi_read(`SPI_REG_STATUS, rd, resp);
    check_eq("empty", 32'h1, rd[1]);
    end_test();

    // One byte more than the queue holds
    start_test("overrun");
    sent.delete();
    for (int i = 0; i < `SPI_RX_DEPTH + 1; i++)
    begin
      b = spi_byte_t'($urandom());
      sent.push_back(b);
      axi_write(`SPI_REG_TXDATA, {24'h0, b}, resp, lat);
    end
    poll_status(32'h1, 32'h0, "the engine to go idle");
    axi_read(`SPI_REG_STATUS, rd, resp);
    check_eq("overrun set", 32'h1, rd[2]);
    check_eq("count", `SPI_RX_DEPTH, rd[7:4]);
    for (int i = 0; i < `SPI_RX_DEPTH; i++)
    begin
      axi_read(`SPI_REG_RXDATA, rd, resp);
      check_eq($sformatf("rx byte %0d", i), sent[i], rd);
    end
    axi_write(`SPI_REG_STATUS, 32'h4, resp, lat);   // Write 1 to clear
    check_eq("clear resp", `SPI_RESP_OKAY, resp);
    axi_read(`SPI_REG_STATUS, rd, resp);
    check_eq("overrun cleared", 32'h0, rd[2]);
    end_test();

    // Empty queue read, read of write-only and write of read-only offset
    start_test("error_resp");
    axi_read(`SPI_REG_RXDATA, rd, resp);
    check_eq("empty rx resp", `SPI_RESP_SLVERR, resp);
    check_eq("empty rx data", 32'h0, rd);
    axi_read(`SPI_REG_TXDATA, rd, resp);
    check_eq("txdata read resp", `SPI_RESP_SLVERR, resp);
    axi_write(`SPI_REG_RXDATA, 32'h0, resp, lat);
    check_eq("rxdata write resp", `SPI_RESP_SLVERR, resp);
    end_test();

    start_test("idle_lines");
    axi_write(`SPI_REG_CTRL, 32'h0, resp, lat);
    check_eq("cs_n released", 32'h1, o_spi_cs_n);
    check_eq("sclk idle level", CPOL, o_spi_sclk);
    end_test();

    asrt_errs = spi_ctrl_top_inst.spi_ctrl_assertions_inst.err_cnt;
    $display("Summary: %0d tests passed, %0d tests with errors, %0d assertion failures",
             tests_passed, tests_failed, asrt_errs);
    if (tests_failed == 0 && asrt_errs == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- verilog/spi_ctrl_top.sv
// Top level of the memory-mapped SPI master controller
// AXI4-Lite slave port and SPI pins as plain ports
// Register decoder, serial engine and receive collector are joined here

`timescale 1ns/100ps

module spi_ctrl_top
  import spi_pkg::*;
(
  input  logic       i_Clk,
  input  logic       i_Rst_L,
  // AXI4-Lite write
  input  logic       i_axi_awvalid,
  output logic       o_axi_awready,
  input  axi_addr_t  i_axi_awaddr,
  input  logic       i_axi_wvalid,
  output logic       o_axi_wready,
  input  reg_data_t  i_axi_wdata,
  output logic       o_axi_bvalid,
  input  logic       i_axi_bready,
  output logic [1:0] o_axi_bresp,
  // AXI4-Lite read
  input  logic       i_axi_arvalid,
  output logic       o_axi_arready,
  input  axi_addr_t  i_axi_araddr,
  output logic       o_axi_rvalid,
  input  logic       i_axi_rready,
  output reg_data_t  o_axi_rdata,
  output logic [1:0] o_axi_rresp,
  // SPI pins
  output logic       o_spi_sclk,
  output logic       o_spi_mosi,
  input  logic       i_spi_miso,
  output logic       o_spi_cs_n
);

  spi_xfer_if xfer_if ();         // Decoder to engine to collector
  rx_queue_if queue_if ();        // Decoder to collector

  spi_reg_decode spi_reg_decode_inst (
    .i_Clk         (i_Clk),
    .i_Rst_L       (i_Rst_L),
    .i_axi_awvalid (i_axi_awvalid),
    .o_axi_awready (o_axi_awready),
    .i_axi_awaddr  (i_axi_awaddr),
    .i_axi_wvalid  (i_axi_wvalid),
    .o_axi_wready  (o_axi_wready),
    .i_axi_wdata   (i_axi_wdata),
    .o_axi_bvalid  (o_axi_bvalid),
    .i_axi_bready  (i_axi_bready),
    .o_axi_bresp   (o_axi_bresp),
    .i_axi_arvalid (i_axi_arvalid),
    .o_axi_arready (o_axi_arready),
    .i_axi_araddr  (i_axi_araddr),
    .o_axi_rvalid  (o_axi_rvalid),
    .i_axi_rready  (i_axi_rready),
    .o_axi_rdata   (o_axi_rdata),
    .o_axi_rresp   (o_axi_rresp),
    .o_spi_cs_n    (o_spi_cs_n),
    .xfer          (xfer_if.decoder),
    .queue         (queue_if.decoder)
  );

  spi_engine spi_engine_inst (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .xfer       (xfer_if.engine),
    .o_spi_sclk (o_spi_sclk),
    .o_spi_mosi (o_spi_mosi),
    .i_spi_miso (i_spi_miso)
  );

  spi_rx_collect spi_rx_collect_inst (
    .i_Clk   (i_Clk),
    .i_Rst_L (i_Rst_L),
    .xfer    (xfer_if.collector),
    .queue   (queue_if.collector)
  );

endmodule

//--- verilog/spi_reg_decode.sv
// AXI4-Lite register decoder of the SPI master controller
// Maps CTRL, TXDATA, RXDATA and STATUS, drives chip select, offers bytes to
// the serial engine and pops the receive queue
// A TXDATA write response is held back until the engine takes the byte

`timescale 1ns/100ps
`include "spi_settings.svh"

module spi_reg_decode
  import spi_pkg::*;
(
  input  logic        i_Clk,
  input  logic        i_Rst_L,
  // Write address and data
  input  logic        i_axi_awvalid,
  output logic        o_axi_awready,
  input  axi_addr_t   i_axi_awaddr,
  input  logic        i_axi_wvalid,
  output logic        o_axi_wready,
  input  reg_data_t   i_axi_wdata,
  // Write response
  output logic        o_axi_bvalid,
  input  logic        i_axi_bready,
  output logic [1:0]  o_axi_bresp,
  // Read address and data
  input  logic        i_axi_arvalid,
  output logic        o_axi_arready,
  input  axi_addr_t   i_axi_araddr,
  output logic        o_axi_rvalid,
  input  logic        i_axi_rready,
  output reg_data_t   o_axi_rdata,
  output logic [1:0]  o_axi_rresp,
  // SPI side
  output logic        o_spi_cs_n,
  spi_xfer_if.decoder xfer,
  rx_queue_if.decoder queue
);

  axi_wr_state_t wr_state;
  logic          wr_hs;           // Address and data taken together
  logic          rd_hs;
  axi_addr_t     wr_reg;          // Word-aligned offsets
  axi_addr_t     rd_reg;
  logic          cs_en;           // CTRL bit 0
  logic          busy;
  reg_data_t     status_word;
  reg_data_t     rd_word;
  logic [1:0]    rd_resp;

  assign wr_reg = {i_axi_awaddr[3:2], 2'b00};
  assign rd_reg = {i_axi_araddr[3:2], 2'b00};

  assign wr_hs         = (wr_state == WR_IDLE) && i_axi_awvalid && i_axi_wvalid;
  assign o_axi_awready = wr_hs;
  assign o_axi_wready  = wr_hs;
  assign o_axi_bvalid  = (wr_state == WR_RESP);

  assign o_axi_arready = !o_axi_rvalid;   // One read in flight at most
  assign rd_hs         = i_axi_arvalid && o_axi_arready;

  assign o_spi_cs_n = ~cs_en;
  assign busy       = xfer.tx_valid || !xfer.tx_ready;

  // Queue controls, single-cycle because the handshakes are
  assign queue.pop         = rd_hs && (rd_reg == `SPI_REG_RXDATA) && !queue.empty;
  assign queue.clr_overrun = wr_hs && (wr_reg == `SPI_REG_STATUS) && i_axi_wdata[2];

  //////////////////////////////////////////////////////////////////////
  // Write channel
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      wr_state      <= WR_IDLE;
      cs_en         <= 1'b0;
      xfer.tx_valid <= 1'b0;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
          if (wr_hs)
          begin
            if (wr_reg == `SPI_REG_CTRL)
              cs_en <= i_axi_wdata[0];
            if (wr_reg == `SPI_REG_TXDATA)
            begin
              xfer.tx_valid <= 1'b1;      // Offer the byte
              wr_state      <= WR_WAIT_ENGINE;
            end
            else
              wr_state <= WR_RESP;
          end
        WR_WAIT_ENGINE:
          if (xfer.tx_ready)              // Engine takes it on this edge
          begin
            xfer.tx_valid <= 1'b0;
            wr_state      <= WR_RESP;
          end
        WR_RESP:
          if (i_axi_bready)
            wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    status_word      = '0;
    status_word[0]   = busy;
    status_word[1]   = queue.empty;
    status_word[2]   = queue.overrun;
    status_word[7:4] = 4'(queue.count);
  end

  always_comb
  begin
    rd_word = '0;
    rd_resp = `SPI_RESP_OKAY;
    case (rd_reg)
      `SPI_REG_CTRL:   rd_word[0] = cs_en;
      `SPI_REG_RXDATA:
        if (queue.empty)
          rd_resp = `SPI_RESP_SLVERR;    // Nothing to give, data stays zero
        else
          rd_word[7:0] = queue.rd_data;
      `SPI_REG_STATUS: rd_word = status_word;
      default:         rd_resp = `SPI_RESP_SLVERR;  // TXDATA is write only
    endcase
  end

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_axi_rvalid <= 1'b0;
    else if (rd_hs)
      o_axi_rvalid <= 1'b1;
    else if (i_axi_rready)
      o_axi_rvalid <= 1'b0;
  end

  // Payload registers
  always_ff @(posedge i_Clk)
  begin
    if (wr_hs)
    begin
      case (wr_reg)
        `SPI_REG_CTRL, `SPI_REG_TXDATA, `SPI_REG_STATUS:
          o_axi_bresp <= `SPI_RESP_OKAY;
        default:
          o_axi_bresp <= `SPI_RESP_SLVERR;  // RXDATA is read only
      endcase
      if (wr_reg == `SPI_REG_TXDATA)
        xfer.tx_byte <= i_axi_wdata[7:0];
    end
    if (rd_hs)
    begin
      o_axi_rdata <= rd_word;
      o_axi_rresp <= rd_resp;
    end
  end

endmodule

//--- verilog/spi_rx_collect.sv
// Receive collector of the SPI master controller
// Circular queue of received bytes with an occupancy count
// A byte that finds the queue full is dropped and sets a sticky overrun flag

`timescale 1ns/100ps
`include "spi_settings.svh"

module spi_rx_collect
  import spi_pkg::*;
(
  input  logic          i_Clk,
  input  logic          i_Rst_L,
  spi_xfer_if.collector xfer,     // Completed bytes from the engine
  rx_queue_if.collector queue     // Read side for the decoder
);

  spi_byte_t mem [`SPI_RX_DEPTH];
  rx_ptr_t   wr_ptr;
  rx_ptr_t   rd_ptr;              // Head of the queue
  rx_count_t count;
  logic      full;
  logic      push;
  logic      pop;

  assign full  = (count == rx_count_t'(`SPI_RX_DEPTH));
  assign push  = xfer.rx_valid && !full;
  assign pop   = queue.pop && !queue.empty;

  assign queue.empty   = (count == '0);
  assign queue.count   = count;
  assign queue.rd_data = mem[rd_ptr];

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      queue.overrun <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;      // Wraps, depth is a power of two
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;      // Idle, or push and pop together
      endcase
      if (xfer.rx_valid && full)
        queue.overrun <= 1'b1;        // Byte lost
      else if (queue.clr_overrun)
        queue.overrun <= 1'b0;
    end
  end

  // Entry is visible the cycle after rx_valid
  always_ff @(posedge i_Clk)
  begin
    if (push)
      mem[wr_ptr] <= xfer.rx_byte;
  end

endmodule
